// ==== files.f ====
+incdir+testbench
hw/cpu_bus_pkg.sv
hw/bus_slot_sequencer.sv
hw/master_decoder.sv
hw/sub_decoder.sv
hw/video_bus_mux.sv
hw/rom_read_mux.sv
hw/cpu_subsystem.sv
testbench/tb_cpu_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_cpu_subsystem \
	-Mdir obj_dir -o sim_cpu_subsystem
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sim_cpu_subsystem
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

exit 0

// ==== testbench/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Where a CPU's read data comes from
typedef enum logic [1:0] {
	src_none = 2'd0,
	src_rom = 2'd1,
	src_video = 2'd2
} rd_src_e;

// One table row: request, vblank action and expected results
typedef struct packed {
	logic sub;
	cpu_bus_pkg::cpu_addr_t addr;
	logic we_n;
	logic lsb;
	logic vb_fall;
	cpu_bus_pkg::video_sel_s exp_sel;
	rd_src_e exp_src;
	logic exp_mirq;
	logic exp_sirq;
	logic hold_check;
} vec_s;

// Select patterns, scroll0 is the top bit
localparam cpu_bus_pkg::video_sel_s SEL_NONE = 6'b000000;
localparam cpu_bus_pkg::video_sel_s SEL_SCROLL0 = 6'b100000;
localparam cpu_bus_pkg::video_sel_s SEL_SCROLL1 = 6'b010000;
localparam cpu_bus_pkg::video_sel_s SEL_OBJECT = 6'b001000;
localparam cpu_bus_pkg::video_sel_s SEL_LATCH0 = 6'b000100;
localparam cpu_bus_pkg::video_sel_s SEL_LATCH1 = 6'b000010;
localparam cpu_bus_pkg::video_sel_s SEL_BACK = 6'b000001;

localparam int NUM_VECTORS = 24;

// sub, addr, we_n, lsb, vb_fall, sel, source, master irq, sub irq, hold check
localparam vec_s VECTORS [NUM_VECTORS] = '{
	'{1'b0, 16'h0123, 1'b1, 1'b0, 1'b0, SEL_SCROLL0, src_video, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h2A5C, 1'b0, 1'b1, 1'b0, SEL_SCROLL1, src_none, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h5FFF, 1'b1, 1'b0, 1'b0, SEL_OBJECT, src_video, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h6000, 1'b0, 1'b0, 1'b0, SEL_LATCH0, src_none, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h6412, 1'b1, 1'b0, 1'b0, SEL_LATCH1, src_video, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h6800, 1'b0, 1'b1, 1'b0, SEL_BACK, src_none, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'h1ABC, 1'b1, 1'b0, 1'b0, SEL_SCROLL0, src_video, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'h3001, 1'b0, 1'b0, 1'b0, SEL_SCROLL1, src_none, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'h4444, 1'b1, 1'b0, 1'b0, SEL_OBJECT, src_video, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'h6003, 1'b1, 1'b0, 1'b0, SEL_LATCH0, src_video, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'h6401, 1'b0, 1'b1, 1'b0, SEL_LATCH1, src_none, 1'b0, 1'b0, 1'b0},
	// Bank switching and the master program ROM
	'{1'b0, 16'h6C00, 1'b0, 1'b1, 1'b0, SEL_NONE, src_none, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h8123, 1'b1, 1'b0, 1'b0, SEL_NONE, src_rom, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'hBFFE, 1'b1, 1'b0, 1'b0, SEL_NONE, src_rom, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h6C00, 1'b0, 1'b0, 1'b0, SEL_NONE, src_none, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'h9234, 1'b1, 1'b0, 1'b0, SEL_NONE, src_rom, 1'b0, 1'b0, 1'b0},
	'{1'b0, 16'hC345, 1'b1, 1'b0, 1'b0, SEL_NONE, src_rom, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'h8765, 1'b1, 1'b0, 1'b0, SEL_NONE, src_rom, 1'b0, 1'b0, 1'b0},
	'{1'b1, 16'hFFF0, 1'b1, 1'b0, 1'b0, SEL_NONE, src_rom, 1'b0, 1'b0, 1'b0},
	// Vblank interrupts and their acknowledges
	'{1'b0, 16'h0040, 1'b1, 1'b0, 1'b1, SEL_SCROLL0, src_video, 1'b1, 1'b1, 1'b0},
	'{1'b0, 16'h7000, 1'b0, 1'b0, 1'b0, SEL_NONE, src_none, 1'b0, 1'b1, 1'b0},
	'{1'b1, 16'h7000, 1'b0, 1'b0, 1'b0, SEL_NONE, src_none, 1'b0, 1'b0, 1'b0},
	// Master reset from the sub, then the master runs again
	'{1'b1, 16'h6800, 1'b0, 1'b0, 1'b0, SEL_NONE, src_none, 1'b0, 1'b0, 1'b1},
	'{1'b0, 16'h0100, 1'b1, 1'b0, 1'b0, SEL_SCROLL0, src_video, 1'b0, 1'b0, 1'b0}
};

`endif

// ==== testbench/tb_cpu_subsystem.sv ====
module tb_cpu_subsystem;

	`include "tb_vectors.svh"

	// Worst case per row plus reset holds
	localparam int TIMEOUT_CYCLES = NUM_VECTORS * 8 + 64;

	logic clk_6m;
	logic rst_n;
	logic vblank_n;
	cpu_bus_pkg::cpu_req_s master_req;
	cpu_bus_pkg::cpu_req_s sub_req;
	cpu_bus_pkg::cpu_data_t video_rdata;
	cpu_bus_pkg::cpu_data_t master_rom_rdata;
	cpu_bus_pkg::cpu_data_t sub_rom_rdata;
	cpu_bus_pkg::video_bus_s video_bus;
	cpu_bus_pkg::rom_addr_t master_rom;
	cpu_bus_pkg::rom_addr_t sub_rom;
	logic master_rom_en;
	logic sub_rom_en;
	cpu_bus_pkg::cpu_data_t master_rdata;
	cpu_bus_pkg::cpu_data_t sub_rdata;
	logic master_done;
	logic sub_done;
	logic master_irq;
	logic sub_irq;
	logic master_reset_n;
	logic [31:0] rnd_state;
	logic bank_model;
	int cycle_count;

	cpu_subsystem cpu_subsystem_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.vblank_n(vblank_n),
		.master_req(master_req),
		.sub_req(sub_req),
		.video_rdata(video_rdata),
		.master_rom_rdata(master_rom_rdata),
		.sub_rom_rdata(sub_rom_rdata),
		.video_bus(video_bus),
		.master_rom(master_rom),
		.master_rom_en(master_rom_en),
		.sub_rom(sub_rom),
		.sub_rom_en(sub_rom_en),
		.master_rdata(master_rdata),
		.sub_rdata(sub_rdata),
		.master_done(master_done),
		.sub_done(sub_done),
		.master_irq(master_irq),
		.sub_irq(sub_irq),
		.master_reset_n(master_reset_n)
	);

	////////////////////
	// Models

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Low address byte mixed with the upper 7 bits
	function automatic cpu_bus_pkg::cpu_data_t rom_byte(input cpu_bus_pkg::rom_addr_t addr);
		return addr[7:0] ^ {1'b0, addr[14:8]};
	endfunction

	// Bank window maps through the bank bit, the rest is linear
	function automatic cpu_bus_pkg::rom_addr_t expected_rom(input logic sub,
		input cpu_bus_pkg::cpu_addr_t addr, input logic bank);
		if (!sub && addr[15:14] == 2'b10) begin
			return {bank, addr[13:0]};
		end
		return addr[14:0];
	endfunction

	assign master_rom_rdata = rom_byte(master_rom);
	assign sub_rom_rdata = rom_byte(sub_rom);

	////////////////////
	// Compare tasks

	task automatic stop_on_failure();
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sel(input string name, input cpu_bus_pkg::video_sel_s expected,
		input cpu_bus_pkg::video_sel_s actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_addr(input string name, input cpu_bus_pkg::video_addr_t expected,
		input cpu_bus_pkg::video_addr_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_rom(input string name, input cpu_bus_pkg::rom_addr_t expected,
		input cpu_bus_pkg::rom_addr_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_data(input string name, input cpu_bus_pkg::cpu_data_t expected,
		input cpu_bus_pkg::cpu_data_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			stop_on_failure();
		end
	endtask

	////////////////////
	// Stimulus

	// Falling edge of vblank_n, sampled on the second edge
	task automatic pulse_vblank();
		@(posedge clk_6m);
		vblank_n <= 1'b0;
		@(posedge clk_6m);
		vblank_n <= 1'b1;
	endtask

	// Master request held through the reset hold, no completion allowed
	task automatic watch_master_reset();
		cpu_bus_pkg::cpu_req_s req;
		int hold;
		req = '0;
		req.valid = 1'b1;
		req.addr = 16'h0077;
		req.we_n = 1'b1;
		@(posedge clk_6m);
		master_req <= req;
		@(negedge clk_6m);
		check_flag("master_reset_n after reset request", 1'b0, master_reset_n);
		hold = 0;
		while (!master_reset_n) begin
			check_flag("master_done during reset hold", 1'b0, master_done);
			hold = hold + 1;
			@(negedge clk_6m);
		end
		check_count("reset hold cycles", cpu_bus_pkg::RESET_HOLD_CYCLES, hold);
		@(posedge clk_6m);
		master_req <= '0;
	endtask

	task automatic apply_row(input int idx, input vec_s v);
		cpu_bus_pkg::cpu_req_s req;
		cpu_bus_pkg::cpu_data_t vid;
		cpu_bus_pkg::cpu_data_t exp_rdata;
		cpu_bus_pkg::rom_addr_t exp_rom;
		logic done_seen;
		string tag;
		tag = $sformatf("row %0d", idx);
		if (v.vb_fall) begin
			pulse_vblank();
		end
		rnd_state = xorshift32(rnd_state);
		req.valid = 1'b1;
		req.addr = v.addr;
		req.we_n = v.we_n;
		req.wdata = {rnd_state[7:1], v.lsb};
		vid = rnd_state[15:8];
		exp_rom = expected_rom(v.sub, v.addr, bank_model);
		@(posedge clk_6m);
		video_rdata <= vid;
		if (v.sub) begin
			sub_req <= req;
		end else begin
			master_req <= req;
		end
		done_seen = 1'b0;
		while (!done_seen) begin
			@(negedge clk_6m);
			done_seen = v.sub ? sub_done : master_done;
		end
		// ROM port while the request still stands
		check_flag({tag, " rom_en"}, v.exp_src == src_rom, v.sub ? sub_rom_en : master_rom_en);
		if (v.exp_src == src_rom) begin
			check_rom({tag, " rom address"}, exp_rom, v.sub ? sub_rom : master_rom);
		end
		@(posedge clk_6m);
		if (v.sub) begin
			sub_req <= '0;
		end else begin
			master_req <= '0;
		end
		if (!v.sub && !v.we_n && v.addr == cpu_bus_pkg::CTRL_BANK) begin
			bank_model = req.wdata[0];
		end
		@(negedge clk_6m);
		check_flag({tag, " bus owner_sub"}, v.sub, video_bus.owner_sub);
		check_sel({tag, " bus sel"}, v.exp_sel, video_bus.sel);
		check_addr({tag, " bus addr"}, v.addr[12:0], video_bus.addr);
		check_flag({tag, " bus we_n"}, v.we_n, video_bus.we_n);
		check_data({tag, " bus wdata"}, v.we_n ? 8'h00 : req.wdata, video_bus.wdata);
		if (v.exp_src != src_none) begin
			exp_rdata = (v.exp_src == src_rom) ? rom_byte(exp_rom) : vid;
			check_data({tag, " rdata"}, exp_rdata, v.sub ? sub_rdata : master_rdata);
		end
		check_flag({tag, " master_irq"}, v.exp_mirq, master_irq);
		check_flag({tag, " sub_irq"}, v.exp_sirq, sub_irq);
		if (v.hold_check) begin
			watch_master_reset();
		end
	endtask

	////////////////////
	// Clock, reset, run

	initial begin
		clk_6m = 1'b0;
		forever #5 clk_6m = ~clk_6m;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_6m);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout after %0d cycles, the test table did not finish", cycle_count);
		stop_on_failure();
	end

	initial begin
		rst_n <= 1'b0;
		vblank_n <= 1'b1;
		master_req <= '0;
		sub_req <= '0;
		video_rdata <= '0;
		rnd_state = 32'd94679;
		bank_model = 1'b0;
		repeat (4) @(posedge clk_6m);
		rst_n <= 1'b1;
		for (int i = 0; i < NUM_VECTORS; i++) begin
			apply_row(i, VECTORS[i]);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== hw/cpu_subsystem.sv ====
module cpu_subsystem (
	input logic clk_6m,
	input logic rst_n,
	input logic vblank_n,
	input cpu_bus_pkg::cpu_req_s master_req,
	input cpu_bus_pkg::cpu_req_s sub_req,
	input cpu_bus_pkg::cpu_data_t video_rdata,
	input cpu_bus_pkg::cpu_data_t master_rom_rdata,
	input cpu_bus_pkg::cpu_data_t sub_rom_rdata,
	output cpu_bus_pkg::video_bus_s video_bus,
	output cpu_bus_pkg::rom_addr_t master_rom,
	output logic master_rom_en,
	output cpu_bus_pkg::rom_addr_t sub_rom,
	output logic sub_rom_en,
	output cpu_bus_pkg::cpu_data_t master_rdata,
	output cpu_bus_pkg::cpu_data_t sub_rdata,
	output logic master_done,
	output logic sub_done,
	output logic master_irq,
	output logic sub_irq,
	output logic master_reset_n
);

	cpu_bus_pkg::slot_e slot;
	cpu_bus_pkg::video_sel_s master_sel;
	cpu_bus_pkg::video_sel_s sub_sel;
	cpu_bus_pkg::rom_addr_t master_rom_addr;
	cpu_bus_pkg::rom_addr_t sub_rom_addr;
	logic master_rom_sel;
	logic sub_rom_sel;
	logic reset_request;

	////////////////////
	// Bus timing

	bus_slot_sequencer bus_slot_sequencer_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.master_req(master_req),
		.sub_req(sub_req),
		.reset_request(reset_request),
		.slot(slot),
		.master_done(master_done),
		.sub_done(sub_done),
		.master_reset_n(master_reset_n)
	);

	////////////////////
	// Address decoders

	master_decoder master_decoder_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.req(master_req),
		.done(master_done),
		.vblank_n(vblank_n),
		.sel(master_sel),
		.rom_sel(master_rom_sel),
		.rom_addr(master_rom_addr),
		.irq(master_irq)
	);

	sub_decoder sub_decoder_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.req(sub_req),
		.done(sub_done),
		.vblank_n(vblank_n),
		.sel(sub_sel),
		.rom_sel(sub_rom_sel),
		.rom_addr(sub_rom_addr),
		.irq(sub_irq),
		.reset_request(reset_request)
	);

	////////////////////
	// Shared video bus and ROM read path

	video_bus_mux video_bus_mux_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.slot(slot),
		.master_req(master_req),
		.sub_req(sub_req),
		.master_sel(master_sel),
		.sub_sel(sub_sel),
		.bus(video_bus)
	);

	rom_read_mux rom_read_mux_i (
		.clk_6m(clk_6m),
		.rst_n(rst_n),
		.master_done(master_done),
		.sub_done(sub_done),
		.master_rom_sel(master_rom_sel),
		.sub_rom_sel(sub_rom_sel),
		.master_rom_addr(master_rom_addr),
		.sub_rom_addr(sub_rom_addr),
		.master_rom_rdata(master_rom_rdata),
		.sub_rom_rdata(sub_rom_rdata),
		.video_rdata(video_rdata),
		.master_rom(master_rom),
		.master_rom_en(master_rom_en),
		.sub_rom(sub_rom),
		.sub_rom_en(sub_rom_en),
		.master_rdata(master_rdata),
		.sub_rdata(sub_rdata)
	);

endmodule

// ==== hw/rom_read_mux.sv ====
module rom_read_mux (
	input logic clk_6m,
	input logic rst_n,
	input logic master_done,
	input logic sub_done,
	input logic master_rom_sel,
	input logic sub_rom_sel,
	input cpu_bus_pkg::rom_addr_t master_rom_addr,
	input cpu_bus_pkg::rom_addr_t sub_rom_addr,
	input cpu_bus_pkg::cpu_data_t master_rom_rdata,
	input cpu_bus_pkg::cpu_data_t sub_rom_rdata,
	input cpu_bus_pkg::cpu_data_t video_rdata,
	output cpu_bus_pkg::rom_addr_t master_rom,
	output logic master_rom_en,
	output cpu_bus_pkg::rom_addr_t sub_rom,
	output logic sub_rom_en,
	output cpu_bus_pkg::cpu_data_t master_rdata,
	output cpu_bus_pkg::cpu_data_t sub_rdata
);

	// ROM ports follow their own decoder
	assign master_rom = master_rom_addr;
	assign master_rom_en = master_rom_sel;
	assign sub_rom = sub_rom_addr;
	assign sub_rom_en = sub_rom_sel;

	////////////////////
	// Read data capture

	// Held until that CPU's next completion
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			master_rdata <= '0;
			sub_rdata <= '0;
		end else begin
			if (master_done) begin
				master_rdata <= master_rom_sel ? master_rom_rdata : video_rdata;
			end
			if (sub_done) begin
				sub_rdata <= sub_rom_sel ? sub_rom_rdata : video_rdata;
			end
		end
	end

endmodule

// ==== hw/video_bus_mux.sv ====
module video_bus_mux (
	input logic clk_6m,
	input logic rst_n,
	input cpu_bus_pkg::slot_e slot,
	input cpu_bus_pkg::cpu_req_s master_req,
	input cpu_bus_pkg::cpu_req_s sub_req,
	input cpu_bus_pkg::video_sel_s master_sel,
	input cpu_bus_pkg::video_sel_s sub_sel,
	output cpu_bus_pkg::video_bus_s bus
);

	logic owner_sub;
	logic owner_we_n;
	cpu_bus_pkg::cpu_req_s owner_req;
	cpu_bus_pkg::video_sel_s owner_sel;

	// Sub owns the bus in its two slots
	assign owner_sub = (slot == cpu_bus_pkg::slot_sub_addr) ||
		(slot == cpu_bus_pkg::slot_sub_data);

	assign owner_req = owner_sub ? sub_req : master_req;
	assign owner_sel = owner_sub ? sub_sel : master_sel;

	// No write strobe without a live request
	assign owner_we_n = owner_req.we_n || !owner_req.valid;

	////////////////////
	// Registered video bus

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			bus.addr <= '0;
			bus.wdata <= '0;
			bus.we_n <= 1'b1;
			bus.sel <= '0;
			bus.owner_sub <= 1'b0;
		end else begin
			bus.addr <= owner_req.addr[12:0];
			bus.wdata <= owner_we_n ? '0 : owner_req.wdata;
			bus.we_n <= owner_we_n;
			bus.sel <= owner_sel;
			bus.owner_sub <= owner_sub;
		end
	end

endmodule

// ==== hw/sub_decoder.sv ====
module sub_decoder (
	input logic clk_6m,
	input logic rst_n,
	input cpu_bus_pkg::cpu_req_s req,
	input logic done,
	input logic vblank_n,
	output cpu_bus_pkg::video_sel_s sel,
	output logic rom_sel,
	output cpu_bus_pkg::rom_addr_t rom_addr,
	output logic irq,
	output logic reset_request
);

	logic vblank_n_q;
	logic vblank_fall;
	logic write_done;
	logic mreset_hit;
	logic ack_hit;

	// Same video map as the master, no backcolor
	always_comb begin
		sel = '0;
		if (req.valid) begin
			sel.scroll0 = req.addr[15:13] == cpu_bus_pkg::SCROLL0_BASE[15:13];
			sel.scroll1 = req.addr[15:13] == cpu_bus_pkg::SCROLL1_BASE[15:13];
			sel.object = req.addr[15:13] == cpu_bus_pkg::OBJECT_BASE[15:13];
			sel.latch0 = req.addr[15:10] == cpu_bus_pkg::CTRL_LATCH0[15:10];
			sel.latch1 = req.addr[15:10] == cpu_bus_pkg::CTRL_LATCH1[15:10];
		end
	end

	assign mreset_hit = req.valid &&
		req.addr[15:10] == cpu_bus_pkg::CTRL_MASTER_RESET[15:10];
	assign ack_hit = req.valid && req.addr[15:10] == cpu_bus_pkg::CTRL_IRQ_ACK[15:10];
	assign write_done = done && !req.we_n;

	// Whole upper half is sub program ROM
	assign rom_sel = req.valid && req.addr[15] == cpu_bus_pkg::SUB_ROM_BASE[15];
	assign rom_addr = req.addr[14:0];

	assign vblank_fall = vblank_n_q && !vblank_n;

	////////////////////
	// Interrupt and master reset

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			vblank_n_q <= 1'b1;
			irq <= 1'b0;
			reset_request <= 1'b0;
		end else begin
			vblank_n_q <= vblank_n;
			reset_request <= write_done && mreset_hit;
			if (vblank_fall) begin
				irq <= 1'b1;
			end else if (write_done && ack_hit) begin
				irq <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/master_decoder.sv ====
module master_decoder (
	input logic clk_6m,
	input logic rst_n,
	input cpu_bus_pkg::cpu_req_s req,
	input logic done,
	input logic vblank_n,
	output cpu_bus_pkg::video_sel_s sel,
	output logic rom_sel,
	output cpu_bus_pkg::rom_addr_t rom_addr,
	output logic irq
);

	logic bank;
	logic vblank_n_q;
	logic vblank_fall;
	logic write_done;
	logic bank_hit;
	logic ack_hit;
	logic in_window;
	logic in_fixed;

	////////////////////
	// Video and control selects

	always_comb begin
		sel = '0;
		if (req.valid) begin
			sel.scroll0 = req.addr[15:13] == cpu_bus_pkg::SCROLL0_BASE[15:13];
			sel.scroll1 = req.addr[15:13] == cpu_bus_pkg::SCROLL1_BASE[15:13];
			sel.object = req.addr[15:13] == cpu_bus_pkg::OBJECT_BASE[15:13];
			sel.latch0 = req.addr[15:10] == cpu_bus_pkg::CTRL_LATCH0[15:10];
			sel.latch1 = req.addr[15:10] == cpu_bus_pkg::CTRL_LATCH1[15:10];
			sel.backcolor = req.addr[15:10] == cpu_bus_pkg::CTRL_BACKCOLOR[15:10];
		end
	end

	// Registers inside the control space
	assign bank_hit = req.valid && req.addr[15:10] == cpu_bus_pkg::CTRL_BANK[15:10];
	assign ack_hit = req.valid && req.addr[15:10] == cpu_bus_pkg::CTRL_IRQ_ACK[15:10];
	assign write_done = done && !req.we_n;

	////////////////////
	// Program ROM

	assign in_window = req.valid &&
		req.addr[15:14] == cpu_bus_pkg::MASTER_BANK_BASE[15:14];
	assign in_fixed = req.valid &&
		req.addr[15:14] == cpu_bus_pkg::MASTER_FIXED_BASE[15:14];
	assign rom_sel = in_window || in_fixed;
	assign rom_addr = in_window ? {bank, req.addr[13:0]} : req.addr[14:0];

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			bank <= 1'b0;
		end else if (write_done && bank_hit) begin
			bank <= req.wdata[0];
		end
	end

	////////////////////
	// Vblank interrupt

	assign vblank_fall = vblank_n_q && !vblank_n;

	// New edge beats an acknowledge in the same cycle
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			vblank_n_q <= 1'b1;
			irq <= 1'b0;
		end else begin
			vblank_n_q <= vblank_n;
			if (vblank_fall) begin
				irq <= 1'b1;
			end else if (write_done && ack_hit) begin
				irq <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk_6m) disable iff (!rst_n) $onehot0(sel));

endmodule

// ==== hw/bus_slot_sequencer.sv ====
module bus_slot_sequencer (
	input logic clk_6m,
	input logic rst_n,
	input cpu_bus_pkg::cpu_req_s master_req,
	input cpu_bus_pkg::cpu_req_s sub_req,
	input logic reset_request,
	output cpu_bus_pkg::slot_e slot,
	output logic master_done,
	output logic sub_done,
	output logic master_reset_n
);

	cpu_bus_pkg::slot_e slot_next;
	cpu_bus_pkg::hold_cnt_t hold_cnt;

	////////////////////
	// Slot FSM, mimics the 1H / 2H phases

	always_comb begin
		case (slot)
			cpu_bus_pkg::slot_master_addr: slot_next = cpu_bus_pkg::slot_master_data;
			cpu_bus_pkg::slot_master_data: slot_next = cpu_bus_pkg::slot_sub_addr;
			cpu_bus_pkg::slot_sub_addr: slot_next = cpu_bus_pkg::slot_sub_data;
			default: slot_next = cpu_bus_pkg::slot_master_addr;
		endcase
	end

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			slot <= cpu_bus_pkg::slot_master_addr;
		end else begin
			slot <= slot_next;
		end
	end

	// Completion at the end of each CPU's data slot
	assign master_done = (slot == cpu_bus_pkg::slot_master_data) && master_req.valid &&
		master_reset_n;
	assign sub_done = (slot == cpu_bus_pkg::slot_sub_data) && sub_req.valid;

	////////////////////
	// Master reset hold

	// Loaded on reset and on every reset request from the sub, counts down to release
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt <= cpu_bus_pkg::hold_cnt_t'(cpu_bus_pkg::RESET_HOLD_CYCLES);
		end else if (reset_request) begin
			hold_cnt <= cpu_bus_pkg::hold_cnt_t'(cpu_bus_pkg::RESET_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign master_reset_n = (hold_cnt == '0);

	// Only one CPU owns the data phase at a time
	assert property (@(posedge clk_6m) disable iff (!rst_n) !(master_done && sub_done));

endmodule

// ==== hw/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

	////////////////////
	// Vector types

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;
	typedef logic [12:0] video_addr_t;
	typedef logic [14:0] rom_addr_t;

	// Bus time slots, one per clk_6m cycle
	typedef enum logic [1:0] {
		slot_master_addr = 2'd0,
		slot_master_data = 2'd1,
		slot_sub_addr = 2'd2,
		slot_sub_data = 2'd3
	} slot_e;

	////////////////////
	// Bus structs

	typedef struct packed {
		logic valid;
		cpu_addr_t addr;
		logic we_n;
		cpu_data_t wdata;
	} cpu_req_s;

	typedef struct packed {
		logic scroll0;
		logic scroll1;
		logic object;
		logic latch0;
		logic latch1;
		logic backcolor;
	} video_sel_s;

	typedef struct packed {
		video_addr_t addr;
		cpu_data_t wdata;
		logic we_n;
		video_sel_s sel;
		logic owner_sub;
	} video_bus_s;

	////////////////////
	// Address map

	localparam cpu_addr_t SCROLL0_BASE = 16'h0000;
	localparam cpu_addr_t SCROLL1_BASE = 16'h2000;
	localparam cpu_addr_t OBJECT_BASE = 16'h4000;
	localparam cpu_addr_t CTRL_BASE = 16'h6000;
	localparam cpu_addr_t MASTER_BANK_BASE = 16'h8000;
	localparam cpu_addr_t MASTER_FIXED_BASE = 16'hC000;
	localparam cpu_addr_t SUB_ROM_BASE = 16'h8000;

	// Control space, decoded on addr bits 12..10
	localparam cpu_addr_t CTRL_LATCH0 = 16'h6000;
	localparam cpu_addr_t CTRL_LATCH1 = 16'h6400;
	localparam cpu_addr_t CTRL_BACKCOLOR = 16'h6800;
	localparam cpu_addr_t CTRL_BANK = 16'h6C00;
	localparam cpu_addr_t CTRL_MASTER_RESET = 16'h6800;
	localparam cpu_addr_t CTRL_IRQ_ACK = 16'h7000;

	// Master reset hold after a reset request
	localparam int RESET_HOLD_CYCLES = 16;
	localparam int HOLD_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
	typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

endpackage
